/* verilog/evu_reg_pkg.sv */
// Register access data width, data word type and access opcodes
package evu_reg_pkg;

   // ******************************
   // Data path
   // ******************************

   // One bus word
   parameter int REG_DATA_W = 32;

   typedef logic [REG_DATA_W-1:0] reg_data_t;

   // ******************************
   // Opcodes
   // ******************************

   // Opcode sits in the low address bits, core index above it
   parameter int OP_W = 2;

   typedef enum logic [OP_W-1:0]
   {
      // Write requests sleep for the addressed core
      OP_SLEEP  = 2'd0,
      // Write loads the event mask
      OP_MASK   = 2'd1,
      // Write drops the buffer bits set in the data
      OP_CLEAR  = 2'd2,
      // Read returns the event buffer
      OP_STATUS = 2'd3
   } reg_op_e;

endpackage

/* verilog/evu_event_pkg.sv */
// Event source widths, event vector layout and type, core state encoding
package evu_event_pkg;

   // ******************************
   // Event sources
   // ******************************

   parameter int TMR_EVT_W = 4;
   parameter int EXT_EVT_W = 8;

   // Timers, one DMA bit, one accelerator bit, external events
   parameter int EVT_W = TMR_EVT_W + 1 + 1 + EXT_EVT_W;

   // Bit positions inside one core's vector
   parameter int EVT_TMR_LSB  = 0;
   parameter int EVT_DMA_BIT  = 4;
   parameter int EVT_HWCE_BIT = 5;
   parameter int EVT_EXT_LSB  = 6;

   typedef logic [EVT_W-1:0] evt_vec_t;

   // ******************************
   // Core power state
   // ******************************

   typedef enum logic [1:0]
   {
      CORE_RUN           = 2'd0,
      CORE_WAIT_SHUTDOWN = 2'd1,
      CORE_SLEEP         = 2'd2
   } core_state_e;

endpackage

/* verilog/evu_event_collect.sv */
// Event collector with external event synchronizer and per-core vector assembly
`timescale 1ns/1ns

module evu_event_collect
   import evu_event_pkg::*;
#(
   parameter int NUM_CORES = 2
)
(
   input  logic                     clk_i,
   input  logic                     rst_ni,
   input  logic [TMR_EVT_W-1:0]     tmr_events_i,
   input  logic [NUM_CORES-1:0]     dma_events_i,
   input  logic                     hwce_event_i,
   input  logic [EXT_EVT_W-1:0]     ext_events_i,
   output evt_vec_t [NUM_CORES-1:0] evt_vec_o
);

   logic [EXT_EVT_W-1:0] ext_meta_q;
   logic [EXT_EVT_W-1:0] ext_sync_q;

   // ******************************
   // External event sync
   // ******************************

   // Two flops, external events come from another clock domain
   always_ff @(posedge clk_i, negedge rst_ni)
   begin
      if (!rst_ni)
      begin
         ext_meta_q <= '0;
         ext_sync_q <= '0;
      end
      else
      begin
         ext_meta_q <= ext_events_i;
         ext_sync_q <= ext_meta_q;
      end
   end

   // ******************************
   // Vector assembly
   // ******************************

   // Shared sources go to every core, DMA bit only to its own core
   always_comb
   begin
      for (int i = 0; i < NUM_CORES; i++)
      begin
         evt_vec_o[i]                           = '0;
         evt_vec_o[i][EVT_TMR_LSB +: TMR_EVT_W] = tmr_events_i;
         evt_vec_o[i][EVT_DMA_BIT]              = dma_events_i[i];
         evt_vec_o[i][EVT_HWCE_BIT]             = hwce_event_i;
         evt_vec_o[i][EVT_EXT_LSB +: EXT_EVT_W] = ext_sync_q;
      end
   end

endmodule

/* verilog/evu_reg_decode.sv */
// Access port decoder with per-core write strobes and registered status read-back
`timescale 1ns/1ns

module evu_reg_decode
   import evu_reg_pkg::*;
   import evu_event_pkg::*;
#(
   parameter int  NUM_CORES = 2,
   localparam int CORE_W    = (NUM_CORES > 1) ? $clog2(NUM_CORES) : 1,
   localparam int ADDR_W    = OP_W + CORE_W
)
(
   input  logic                     clk_i,
   input  logic                     rst_ni,
   input  logic                     req_i,
   input  logic                     wen_i,
   input  logic [ADDR_W-1:0]        addr_i,
   input  reg_data_t                wdata_i,
   input  evt_vec_t [NUM_CORES-1:0] evt_buf_i,
   output logic                     gnt_o,
   output logic                     r_valid_o,
   output reg_data_t                r_rdata_o,
   output logic [NUM_CORES-1:0]     sleep_req_o,
   output logic [NUM_CORES-1:0]     mask_we_o,
   output evt_vec_t                 mask_o,
   output evt_vec_t [NUM_CORES-1:0] clear_o
);

   logic              wr_en;
   logic              rd_en;
   logic [CORE_W-1:0] core_idx;
   logic              core_hit;
   reg_op_e           op;
   reg_data_t         r_rdata_d;
   reg_data_t         r_rdata_q;
   logic              r_valid_q;

   // wen_i low means write
   assign wr_en    = req_i & ~wen_i;
   assign rd_en    = req_i & wen_i;
   assign op       = reg_op_e'(addr_i[OP_W-1:0]);
   assign core_idx = addr_i[ADDR_W-1:OP_W];
   assign core_hit = (int'(core_idx) < NUM_CORES);

   // No wait states on this port
   assign gnt_o  = req_i;
   assign mask_o = wdata_i[EVT_W-1:0];

   // ******************************
   // Write strobes
   // ******************************

   always_comb
   begin
      sleep_req_o = '0;
      mask_we_o   = '0;
      clear_o     = '0;
      if (wr_en && core_hit)
      begin
         case (op)
            OP_SLEEP:  sleep_req_o[core_idx] = 1'b1;
            OP_MASK:   mask_we_o[core_idx]   = 1'b1;
            OP_CLEAR:  clear_o[core_idx]     = wdata_i[EVT_W-1:0];
            // Status is read only
            default:
            begin
            end
         endcase
      end
   end

   // ******************************
   // Read path
   // ******************************

   always_comb
   begin
      r_rdata_d = '0;
      if (rd_en && core_hit && (op == OP_STATUS))
      begin
         r_rdata_d = {{(REG_DATA_W - EVT_W){1'b0}}, evt_buf_i[core_idx]};
      end
   end

   always_ff @(posedge clk_i, negedge rst_ni)
   begin
      if (!rst_ni)
      begin
         r_valid_q <= 1'b0;
         r_rdata_q <= '0;
      end
      else
      begin
         r_valid_q <= req_i;
         r_rdata_q <= r_rdata_d;
      end
   end

   assign r_valid_o = r_valid_q;
   assign r_rdata_o = r_rdata_q;

endmodule

/* verilog/evu_event_buffer.sv */
// Per-core sticky event buffer, event mask register and wake detection
`timescale 1ns/1ns

module evu_event_buffer
   import evu_event_pkg::*;
(
   input  logic     clk_i,
   input  logic     rst_ni,
   input  evt_vec_t evt_i,
   input  evt_vec_t clear_i,
   input  logic     mask_we_i,
   input  evt_vec_t mask_i,
   output evt_vec_t evt_buf_o,
   output logic     evt_detect_o
);

   evt_vec_t evt_buf_q;
   evt_vec_t evt_buf_d;
   evt_vec_t mask_q;

   // ******************************
   // Sticky buffer
   // ******************************

   // Clear first, then set, so a same-cycle event survives the clear
   assign evt_buf_d = (evt_buf_q & ~clear_i) | evt_i;

   always_ff @(posedge clk_i, negedge rst_ni)
   begin
      if (!rst_ni)
      begin
         evt_buf_q <= '0;
      end
      else
      begin
         evt_buf_q <= evt_buf_d;
      end
   end

   // ******************************
   // Event mask
   // ******************************

   always_ff @(posedge clk_i, negedge rst_ni)
   begin
      if (!rst_ni)
      begin
         mask_q <= '0;
      end
      else if (mask_we_i)
      begin
         mask_q <= mask_i;
      end
   end

   // Any buffered and enabled event wakes the core
   assign evt_detect_o = |(evt_buf_q & mask_q);
   assign evt_buf_o    = evt_buf_q;

endmodule

/* verilog/evu_core_sm.sv */
// Per-core sleep and wake FSM driving fetch enable and core clock enable
`timescale 1ns/1ns

module evu_core_sm
   import evu_event_pkg::*;
(
   input  logic clk_i,
   input  logic rst_ni,
   input  logic sleep_req_i,
   input  logic ready_to_shutdown_i,
   input  logic evt_detect_i,
   output logic fetch_en_o,
   output logic core_clk_en_o
);

   core_state_e state_q;
   core_state_e state_d;

   // ******************************
   // Next state
   // ******************************

   always_comb
   begin
      state_d = state_q;
      case (state_q)
         CORE_RUN:
         begin
            // A pending enabled event refuses the sleep request
            if (sleep_req_i && !evt_detect_i)
            begin
               state_d = CORE_WAIT_SHUTDOWN;
            end
         end

         CORE_WAIT_SHUTDOWN:
         begin
            // Fetch is off, wait for the pipeline to drain
            if (evt_detect_i)
            begin
               state_d = CORE_RUN;
            end
            else if (ready_to_shutdown_i)
            begin
               state_d = CORE_SLEEP;
            end
         end

         CORE_SLEEP:
         begin
            if (evt_detect_i)
            begin
               state_d = CORE_RUN;
            end
         end

         default:
         begin
            state_d = CORE_RUN;
         end
      endcase
   end

   always_ff @(posedge clk_i, negedge rst_ni)
   begin
      if (!rst_ni)
      begin
         state_q <= CORE_RUN;
      end
      else
      begin
         state_q <= state_d;
      end
   end

   // Outputs straight from the state register
   assign fetch_en_o    = (state_q == CORE_RUN);
   assign core_clk_en_o = (state_q != CORE_SLEEP);

endmodule

/* verilog/evu_top.sv */
// Event unit top level with collector, register decoder, event buffers and core FSMs
`timescale 1ns/1ns

module evu_top
   import evu_reg_pkg::*;
   import evu_event_pkg::*;
#(
   parameter int  NUM_CORES = 2,
   localparam int CORE_W    = (NUM_CORES > 1) ? $clog2(NUM_CORES) : 1,
   localparam int ADDR_W    = OP_W + CORE_W
)
(
   input  logic                 clk_i,
   input  logic                 rst_ni,

   // Event sources
   input  logic [TMR_EVT_W-1:0] tmr_events_i,
   input  logic [NUM_CORES-1:0] dma_events_i,
   input  logic                 hwce_event_i,
   input  logic [EXT_EVT_W-1:0] ext_events_i,
   input  logic [NUM_CORES-1:0] ready_to_shutdown_i,

   // Peripheral access port
   input  logic                 req_i,
   input  logic                 wen_i,
   input  logic [ADDR_W-1:0]    addr_i,
   input  reg_data_t            wdata_i,
   output logic                 gnt_o,
   output logic                 r_valid_o,
   output reg_data_t            r_rdata_o,

   // Core control
   output logic [NUM_CORES-1:0] fetch_en_o,
   output logic [NUM_CORES-1:0] core_clk_en_o
);

   evt_vec_t [NUM_CORES-1:0] evt_vec;
   evt_vec_t [NUM_CORES-1:0] evt_buf;
   evt_vec_t [NUM_CORES-1:0] clear;
   evt_vec_t                 mask;
   logic [NUM_CORES-1:0]     mask_we;
   logic [NUM_CORES-1:0]     sleep_req;
   logic [NUM_CORES-1:0]     evt_detect;

   // ******************************
   // Shared blocks
   // ******************************

   evu_event_collect #(
      .NUM_CORES    (NUM_CORES)
   ) u_event_collect (
      .clk_i        (clk_i),
      .rst_ni       (rst_ni),
      .tmr_events_i (tmr_events_i),
      .dma_events_i (dma_events_i),
      .hwce_event_i (hwce_event_i),
      .ext_events_i (ext_events_i),
      .evt_vec_o    (evt_vec)
   );

   evu_reg_decode #(
      .NUM_CORES   (NUM_CORES)
   ) u_reg_decode (
      .clk_i       (clk_i),
      .rst_ni      (rst_ni),
      .req_i       (req_i),
      .wen_i       (wen_i),
      .addr_i      (addr_i),
      .wdata_i     (wdata_i),
      .evt_buf_i   (evt_buf),
      .gnt_o       (gnt_o),
      .r_valid_o   (r_valid_o),
      .r_rdata_o   (r_rdata_o),
      .sleep_req_o (sleep_req),
      .mask_we_o   (mask_we),
      .mask_o      (mask),
      .clear_o     (clear)
   );

   // ******************************
   // Per-core slices
   // ******************************

   for (genvar i = 0; i < NUM_CORES; i++)
   begin : g_core
      evu_event_buffer u_event_buffer (
         .clk_i        (clk_i),
         .rst_ni       (rst_ni),
         .evt_i        (evt_vec[i]),
         .clear_i      (clear[i]),
         .mask_we_i    (mask_we[i]),
         .mask_i       (mask),
         .evt_buf_o    (evt_buf[i]),
         .evt_detect_o (evt_detect[i])
      );

      evu_core_sm u_core_sm (
         .clk_i               (clk_i),
         .rst_ni              (rst_ni),
         .sleep_req_i         (sleep_req[i]),
         .ready_to_shutdown_i (ready_to_shutdown_i[i]),
         .evt_detect_i        (evt_detect[i]),
         .fetch_en_o          (fetch_en_o[i]),
         .core_clk_en_o       (core_clk_en_o[i])
      );
   end

endmodule

/* testbench/evu_properties.sv */
// Concurrent assertions on the event unit port behaviour, bound to the top level
`timescale 1ns/1ns

module evu_properties
#(
   parameter int NUM_CORES = 2
)
(
   input logic                 clk_i,
   input logic                 rst_ni,
   input logic                 req_i,
   input logic                 gnt_i,
   input logic                 r_valid_i,
   input logic [NUM_CORES-1:0] fetch_en_i,
   input logic [NUM_CORES-1:0] core_clk_en_i
);

   // ******************************
   // Access port
   // ******************************

   // No wait states
   gnt_follows_req: assert property (@(posedge clk_i) disable iff (!rst_ni)
      gnt_i == req_i)
      else $error("gnt_o differs from req_i");

   rvalid_after_req: assert property (@(posedge clk_i) disable iff (!rst_ni)
      req_i |=> r_valid_i)
      else $error("r_valid_o missing one cycle after a request");

   no_rvalid_without_req: assert property (@(posedge clk_i) disable iff (!rst_ni)
      !req_i |=> !r_valid_i)
      else $error("r_valid_o high without a request in the cycle before");

   // ******************************
   // Core control
   // ******************************

   // A gated core must not fetch
   clk_off_fetch_off: assert property (@(posedge clk_i) disable iff (!rst_ni)
      ((~core_clk_en_i) & fetch_en_i) == '0)
      else $error("fetch_en_o high while core_clk_en_o is low");

endmodule

/* testbench/tb_evu.sv */
// Event unit testbench with clock, reset, LFSR, stimulus table, compare tasks and summary
`timescale 1ns/1ns

module tb_evu
   import evu_reg_pkg::*;
   import evu_event_pkg::*;
();

   localparam int        NUM_CORES = 2;
   localparam int        CORE_W    = 1;
   localparam int        ADDR_W    = OP_W + CORE_W;
   localparam int        TIMEOUT   = 20;
   localparam reg_data_t EN_RUN    = 32'h3;
   localparam reg_data_t EN_WAIT   = 32'h2;
   localparam reg_data_t EN_SLEEP  = 32'h0;

   typedef enum logic [1:0] {ACT_WRITE, ACT_READ, ACT_PULSE, ACT_READY} act_e;

   // Enable rows expect fetch_en in bit 0 and core_clk_en in bit 1
   typedef struct packed {
      act_e              act;
      logic [CORE_W-1:0] core;
      reg_op_e           op;
      reg_data_t         data;
      reg_data_t         exp;
      logic              wait_en;
   } row_t;

   logic                 clk_i;
   logic                 rst_ni;
   logic [TMR_EVT_W-1:0] tmr_events_i;
   logic [NUM_CORES-1:0] dma_events_i;
   logic                 hwce_event_i;
   logic [EXT_EVT_W-1:0] ext_events_i;
   logic [NUM_CORES-1:0] ready_to_shutdown_i;
   logic                 req_i;
   logic                 wen_i;
   logic [ADDR_W-1:0]    addr_i;
   reg_data_t            wdata_i;
   logic                 gnt_o;
   logic                 r_valid_o;
   reg_data_t            r_rdata_o;
   logic [NUM_CORES-1:0] fetch_en_o;
   logic [NUM_CORES-1:0] core_clk_en_o;

   row_t        stim_table [$];
   string       row_name [$];
   evt_vec_t    model_buf [NUM_CORES];
   logic [31:0] lfsr_q;
   int          checks;
   int          errors;

   evu_top #(
      .NUM_CORES           (NUM_CORES)
   ) u_evu_top (
      .clk_i               (clk_i),
      .rst_ni              (rst_ni),
      .tmr_events_i        (tmr_events_i),
      .dma_events_i        (dma_events_i),
      .hwce_event_i        (hwce_event_i),
      .ext_events_i        (ext_events_i),
      .ready_to_shutdown_i (ready_to_shutdown_i),
      .req_i               (req_i),
      .wen_i               (wen_i),
      .addr_i              (addr_i),
      .wdata_i             (wdata_i),
      .gnt_o               (gnt_o),
      .r_valid_o           (r_valid_o),
      .r_rdata_o           (r_rdata_o),
      .fetch_en_o          (fetch_en_o),
      .core_clk_en_o       (core_clk_en_o)
   );

   bind evu_top evu_properties #(
      .NUM_CORES       (NUM_CORES)
   ) u_evu_properties (
      .clk_i           (clk_i),
      .rst_ni          (rst_ni),
      .req_i           (req_i),
      .gnt_i           (gnt_o),
      .r_valid_i       (r_valid_o),
      .fetch_en_i      (fetch_en_o),
      .core_clk_en_i   (core_clk_en_o)
   );

   initial
   begin
      clk_i = 1'b0;
      forever #20 clk_i = ~clk_i;
   end

   // ******************************
   // Random bits and table build
   // ******************************

   // Galois form, x^32 + x^22 + x^2 + x + 1
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      return (s >> 1) ^ (s[0] ? 32'h8020_0003 : 32'h0);
   endfunction

   task automatic take_bits(input int n, output logic [31:0] val);
      val = '0;
      for (int k = 0; k < n; k++)
      begin
         lfsr_q = lfsr_next(lfsr_q);
         val    = {val[30:0], lfsr_q[0]};
      end
   endtask

   task automatic add_row(input act_e act, input int core, input reg_op_e op,
                          input reg_data_t data, input reg_data_t exp,
                          input logic wait_en, input string name);
      row_t r;
      r.act     = act;
      r.core    = CORE_W'(core);
      r.op      = op;
      r.data    = data;
      r.exp     = exp;
      r.wait_en = wait_en;
      stim_table.push_back(r);
      row_name.push_back(name);
   endtask

   // Shared bits land in every buffer, the DMA bit only in its own core
   task automatic add_pulse(input int core, input evt_vec_t vec, input string name);
      for (int c = 0; c < NUM_CORES; c++)
      begin
         model_buf[c] |= (c == core) ? vec : (vec & ~(evt_vec_t'(1) << EVT_DMA_BIT));
      end
      add_row(ACT_PULSE, core, OP_SLEEP, reg_data_t'(vec), '0, 1'b0, name);
   endtask

   task automatic add_status_read(input int core, input string name);
      add_row(ACT_READ, core, OP_STATUS, '0, reg_data_t'(model_buf[core]), 1'b0, name);
   endtask

   // ******************************
   // Compare tasks
   // ******************************

   task automatic compare_status(input string sig, input evt_vec_t got, input evt_vec_t exp);
      checks++;
      if (got !== exp)
      begin
         errors++;
         $display("CHECK FAILED %s got 0x%h expected 0x%h", sig, got, exp);
      end
   endtask

   task automatic compare_rdata(input string sig, input reg_data_t got, input reg_data_t exp);
      checks++;
      if (got !== exp)
      begin
         errors++;
         $display("CHECK FAILED %s got 0x%h expected 0x%h", sig, got, exp);
      end
   endtask

   task automatic compare_bit(input string sig, input logic got, input logic exp);
      checks++;
      if (got !== exp)
      begin
         errors++;
         $display("CHECK FAILED %s got 0x%h expected 0x%h", sig, got, exp);
      end
   endtask

   // ******************************
   // Row actions
   // ******************************

   task automatic drive_request(input row_t r, input logic wen);
      @(posedge clk_i);
      req_i   <= 1'b1;
      wen_i   <= wen;
      addr_i  <= {r.core, r.op};
      wdata_i <= r.data;
   endtask

   // Other core never sleeps in this sequence
   task automatic expect_enables(input row_t r);
      int cycles;
      int limit;
      cycles = 0;
      limit  = r.wait_en ? TIMEOUT : 1;
      do
      begin
         @(negedge clk_i);
         cycles++;
      end
      while (!(fetch_en_o[r.core] === r.exp[0] && core_clk_en_o[r.core] === r.exp[1])
             && cycles < limit);
      if (r.wait_en
          && !(fetch_en_o[r.core] === r.exp[0] && core_clk_en_o[r.core] === r.exp[1]))
      begin
         errors++;
         $display("timeout while waiting for the enables of core %0d", r.core);
      end
      compare_bit("fetch_en_o", fetch_en_o[r.core], r.exp[0]);
      compare_bit("core_clk_en_o", core_clk_en_o[r.core], r.exp[1]);
      compare_bit("fetch_en_o other core", fetch_en_o[~r.core], 1'b1);
      compare_bit("core_clk_en_o other core", core_clk_en_o[~r.core], 1'b1);
   endtask

   task automatic read_reg(input row_t r);
      int cycles;
      drive_request(r, 1'b1);
      @(negedge clk_i);
      compare_bit("gnt_o", gnt_o, 1'b1);
      @(posedge clk_i);
      req_i  <= 1'b0;
      cycles = 0;
      do
      begin
         @(negedge clk_i);
         cycles++;
      end
      while (!r_valid_o && cycles < TIMEOUT);
      if (!r_valid_o)
      begin
         errors++;
         $display("timeout while waiting for r_valid_o");
      end
      else if (cycles != 1)
      begin
         errors++;
         $display("r_valid_o came %0d cycles after the request instead of one", cycles);
      end
      compare_status("r_rdata_o status", r_rdata_o[EVT_W-1:0], r.exp[EVT_W-1:0]);
      compare_rdata("r_rdata_o", r_rdata_o, r.exp);
   endtask

   task automatic pulse_events(input row_t r);
      logic [NUM_CORES-1:0] dma;
      dma         = '0;
      dma[r.core] = r.data[EVT_DMA_BIT];
      @(posedge clk_i);
      tmr_events_i <= r.data[EVT_TMR_LSB +: TMR_EVT_W];
      hwce_event_i <= r.data[EVT_HWCE_BIT];
      ext_events_i <= r.data[EVT_EXT_LSB +: EXT_EVT_W];
      dma_events_i <= dma;
      @(posedge clk_i);
      tmr_events_i <= '0;
      hwce_event_i <= 1'b0;
      ext_events_i <= '0;
      dma_events_i <= '0;
      // Two more edges through the synchronizer
      repeat (2) @(posedge clk_i);
   endtask

   // ******************************
   // Main sequence
   // ******************************

   initial
   begin
      logic [31:0] bits;
      evt_vec_t    vec;
      row_t        r;
      int          errs_before;
      rst_ni              = 1'b0;
      tmr_events_i        = '0;
      dma_events_i        = '0;
      hwce_event_i        = 1'b0;
      ext_events_i        = '0;
      ready_to_shutdown_i = '0;
      req_i               = 1'b0;
      wen_i               = 1'b1;
      addr_i              = '0;
      wdata_i             = '0;
      lfsr_q              = 32'h0aee_418d;
      checks              = 0;
      errors              = 0;
      model_buf           = '{default: '0};

      take_bits(TMR_EVT_W, bits);
      vec                                = '0;
      vec[EVT_TMR_LSB +: TMR_EVT_W]      = bits[TMR_EVT_W-1:0];
      vec[EVT_HWCE_BIT]                  = 1'b1;
      vec[EVT_DMA_BIT]                   = 1'b1;
      add_pulse(0, vec, "timer, accelerator and core 0 DMA pulse");
      add_status_read(0, "status core 0 after collection");
      add_status_read(1, "status core 1 after collection");
      take_bits(EXT_EVT_W, bits);
      vec                                = '0;
      vec[EVT_EXT_LSB +: EXT_EVT_W]      = bits[EXT_EVT_W-1:0];
      add_pulse(1, vec, "external event pulse");
      add_status_read(0, "status core 0 after external events");
      add_status_read(1, "status core 1 after external events");
      // Keep the accelerator bit so the wake test has a buffered event
      take_bits(EVT_W, bits);
      vec               = bits[EVT_W-1:0];
      vec[EVT_HWCE_BIT] = 1'b0;
      model_buf[0]     &= ~vec;
      add_row(ACT_WRITE, 0, OP_CLEAR, reg_data_t'(vec), EN_RUN, 1'b0, "clear core 0");
      add_status_read(0, "status core 0 after clear");
      add_status_read(1, "status core 1 after clear");
      add_row(ACT_WRITE, 0, OP_SLEEP, '0, EN_WAIT, 1'b0, "sleep request core 0");
      add_row(ACT_READY, 0, OP_SLEEP, 32'h1, EN_SLEEP, 1'b0, "shutdown ready core 0");
      add_row(ACT_WRITE, 0, OP_MASK, 32'h1 << EVT_HWCE_BIT, EN_RUN, 1'b1, "mask wakes core 0");
      add_row(ACT_READY, 0, OP_SLEEP, '0, EN_RUN, 1'b0, "shutdown ready released");
      add_row(ACT_WRITE, 0, OP_SLEEP, '0, EN_RUN, 1'b0, "sleep refused by masked event");
      // Core 0 has a nonzero mask and buffer here
      add_row(ACT_READ, 0, OP_MASK, '0, '0, 1'b0, "mask read returns zero");

      repeat (5) @(posedge clk_i);
      rst_ni <= 1'b1;

      foreach (stim_table[i])
      begin
         r           = stim_table[i];
         errs_before = errors;
         case (r.act)
            ACT_WRITE:
            begin
               drive_request(r, 1'b0);
               @(posedge clk_i);
               req_i <= 1'b0;
               wen_i <= 1'b1;
               expect_enables(r);
            end
            ACT_READ:  read_reg(r);
            ACT_PULSE: pulse_events(r);
            default:
            begin
               @(posedge clk_i);
               ready_to_shutdown_i[r.core] <= r.data[0];
               @(posedge clk_i);
               expect_enables(r);
            end
         endcase
         $display("row %0d %s: %s", i, row_name[i], (errors == errs_before) ? "ok" : "failed");
      end

      $display("rows %0d, checks %0d, errors %0d", stim_table.size(), checks, errors);
      if (errors == 0)
      begin
         $display("ALL CHECKS PASSED");
      end
      else
      begin
         $display("CHECKS FAILED");
      end
      $finish;
   end

endmodule

/* sources.f */
verilog/evu_reg_pkg.sv
verilog/evu_event_pkg.sv
verilog/evu_event_collect.sv
verilog/evu_reg_decode.sv
verilog/evu_event_buffer.sv
verilog/evu_core_sm.sv
verilog/evu_top.sv
testbench/evu_properties.sv
testbench/tb_evu.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the event unit testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert -f sources.f --top-module tb_evu
./obj_dir/Vtb_evu | tee sim.log

if grep -q "CHECKS FAILED" sim.log; then
   echo "simulation reported failures"
   exit 1
fi
echo "simulation finished without failures"
